// File: verilog/idli_settings.svh
`ifndef IDLI_SETTINGS_SVH
`define IDLI_SETTINGS_SVH

// Number of bits handled by the datapath in a single clock cycle.
`define IDLI_SLICE_W 4

// Number of bits in an architectural register or an instruction encoding.
`define IDLI_WORD_W 16

// Number of slices in a word.
// One instruction takes this many cycles, which together form a beat.
`define IDLI_NUM_SLICES 4

// Number of architectural registers.
// Register 0 is hardwired to zero.
`define IDLI_NUM_REGS 16

`endif

// File: verilog/idli_pkg.sv
`include "idli_settings.svh"

// Shared types for the nibble-serial execution unit.
package idli_pkg;

  // One slice of a word, as processed in one cycle.
  typedef logic [`IDLI_SLICE_W-1:0] slice_t;

  // A full register value or instruction encoding.
  typedef logic [`IDLI_WORD_W-1:0] word_t;

  // Index of an architectural register.
  typedef logic [$clog2(`IDLI_NUM_REGS)-1:0] reg_t;

  // Position of the current slice within a beat.
  typedef logic [$clog2(`IDLI_NUM_SLICES)-1:0] ctr_t;

  // Immediate carried in the low byte of LDI.
  typedef logic [2*`IDLI_SLICE_W-1:0] imm_t;

  // Conditional-execution mask loaded by COND.
  typedef logic [2*`IDLI_SLICE_W-1:0] cond_t;

  // Opcodes held in the top four bits of the encoding.
  // The compare group sits in one contiguous run after the ALU group.
  typedef enum logic [3:0] {
    OP_NOP     = 4'h0,
    OP_LDI     = 4'h1,
    OP_ADD     = 4'h2,
    OP_SUB     = 4'h3,
    OP_AND     = 4'h4,
    OP_OR      = 4'h5,
    OP_XOR     = 4'h6,
    OP_CMP_EQ  = 4'h7,
    OP_CMP_NE  = 4'h8,
    OP_CMP_LT  = 4'h9,
    OP_CMP_LTU = 4'ha,
    OP_CMP_GE  = 4'hb,
    OP_CMP_GEU = 4'hc,
    OP_COND    = 4'hd
  } op_t;

endpackage

// File: verilog/idli_decode.sv
`timescale 1ns/1ps

`include "idli_settings.svh"

// Instruction capture and decode.
// This block owns the slice counter that defines the beat.
module idli_decode (
  input  var logic            i_ex_gck,
  input  var logic            i_ex_rst_n,

  input  var idli_pkg::word_t i_de_enc,
  input  var logic            i_de_enc_vld,

  output var logic            o_de_ready,
  output var idli_pkg::ctr_t  o_de_ctr,
  output var logic            o_de_vld,
  output var idli_pkg::op_t   o_de_op,
  output var idli_pkg::reg_t  o_de_dst,
  output var idli_pkg::reg_t  o_de_lhs,
  output var idli_pkg::reg_t  o_de_rhs,
  output var idli_pkg::imm_t  o_de_imm,
  output var logic            o_de_dst_wr
);

  import idli_pkg::*;

  // Free running slice counter.
  ctr_t ctr_q;

  // Valid bit and opcode of the instruction that executes in this beat.
  logic vld_q;
  op_t  op_q;

  // Operand fields of the held instruction.
  reg_t dst_q;
  reg_t lhs_q;
  reg_t rhs_q;
  imm_t imm_q;

  // High on the edge where a new encoding is taken in.
  logic accept;

  // The counter wraps every beat and never stops, since nothing stalls.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + ctr_t'(1);
    end
  end

  // The source may present an encoding in the last slice of each beat.
  always_comb o_de_ready = ctr_q == ctr_t'(`IDLI_NUM_SLICES - 1);

  always_comb accept = o_de_ready && i_de_enc_vld;

  // At every beat boundary the valid bit is refreshed.
  // Without an encoding the next beat becomes a bubble.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      vld_q <= 1'b0;
      op_q  <= OP_NOP;
    end else if (o_de_ready) begin
      vld_q <= i_de_enc_vld;
      if (i_de_enc_vld) begin
        op_q <= op_t'(i_de_enc[15:12]);
      end
    end
  end

  // Operand fields only matter while the valid bit is set.
  // The low byte doubles as the immediate of LDI and COND.
  always_ff @(posedge i_ex_gck) begin
    if (accept) begin
      dst_q <= i_de_enc[11:8];
      lhs_q <= i_de_enc[7:4];
      rhs_q <= i_de_enc[3:0];
      imm_q <= i_de_enc[7:0];
    end
  end

  // LDI and the plain ALU operations are the only register writers.
  always_comb begin
    case (op_q)
      OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: o_de_dst_wr = 1'b1;
      default:                                       o_de_dst_wr = 1'b0;
    endcase
  end

  always_comb o_de_ctr = ctr_q;
  always_comb o_de_vld = vld_q;
  always_comb o_de_op  = op_q;
  always_comb o_de_dst = dst_q;
  always_comb o_de_lhs = lhs_q;
  always_comb o_de_rhs = rhs_q;
  always_comb o_de_imm = imm_q;

endmodule

// File: verilog/idli_rf.sv
`timescale 1ns/1ps

`include "idli_settings.svh"

// Register file stored as slices.
// Each operand port reads one slice per cycle and one slice is written per cycle.
module idli_rf (
  input  var logic             i_ex_gck,

  input  var idli_pkg::ctr_t   i_rf_ctr,
  input  var idli_pkg::reg_t   i_rf_lhs,
  input  var idli_pkg::reg_t   i_rf_rhs,

  input  var idli_pkg::reg_t   i_rf_dst,
  input  var logic             i_rf_dst_en,
  input  var idli_pkg::slice_t i_rf_dst_data,

  output var idli_pkg::slice_t o_rf_lhs_data,
  output var idli_pkg::slice_t o_rf_rhs_data
);

  import idli_pkg::*;

  // Register contents, indexed by register and then by slice position.
  slice_t regs_q [`IDLI_NUM_REGS][`IDLI_NUM_SLICES];

  // Reads are combinational so the ALU sees the slice in the same cycle.
  // Register 0 is forced to zero here rather than held in storage.
  always_comb begin
    if (i_rf_lhs == '0) begin
      o_rf_lhs_data = '0;
    end else begin
      o_rf_lhs_data = regs_q[i_rf_lhs][i_rf_ctr];
    end
  end

  always_comb begin
    if (i_rf_rhs == '0) begin
      o_rf_rhs_data = '0;
    end else begin
      o_rf_rhs_data = regs_q[i_rf_rhs][i_rf_ctr];
    end
  end

  // The slice computed in this cycle is written back in place.
  // Later slices of the same instruction still read the old value of the
  // destination, so a destination equal to a source behaves as expected.
  always_ff @(posedge i_ex_gck) begin
    if (i_rf_dst_en && i_rf_dst != '0) begin
      regs_q[i_rf_dst][i_rf_ctr] <= i_rf_dst_data;
    end
  end

endmodule

// File: verilog/idli_alu.sv
`timescale 1ns/1ps

`include "idli_settings.svh"

// Serial ALU.
// One slice is computed per cycle and the carry is saved between slices.
module idli_alu (
  input  var logic             i_ex_gck,
  input  var logic             i_ex_rst_n,

  input  var idli_pkg::ctr_t   i_alu_ctr,
  input  var idli_pkg::op_t    i_alu_op,
  input  var idli_pkg::imm_t   i_alu_imm,
  input  var idli_pkg::slice_t i_alu_lhs,
  input  var idli_pkg::slice_t i_alu_rhs,

  output var idli_pkg::slice_t o_alu_out,
  output var logic             o_alu_flag_z,
  output var logic             o_alu_flag_n,
  output var logic             o_alu_flag_c,
  output var logic             o_alu_flag_v
);

  import idli_pkg::*;

  // Set for SUB and every compare, which all subtract rhs from lhs.
  logic sub_op;

  // High in the first slice of a beat.
  logic first;

  // Adder inputs and the sum with its carry out in the top bit.
  slice_t                rhs_eff;
  logic                  cin;
  logic [`IDLI_SLICE_W:0] sum;

  // Slice of the LDI immediate for this position.
  slice_t imm_slice;

  // Carry and running zero flag from earlier slices.
  logic carry_q;
  logic zero_q;
  logic zero_acc;

  always_comb first = i_alu_ctr == '0;

  always_comb begin
    case (i_alu_op)
      OP_SUB, OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT, OP_CMP_LTU, OP_CMP_GE, OP_CMP_GEU: begin
        sub_op = 1'b1;
      end
      default: begin
        sub_op = 1'b0;
      end
    endcase
  end

  // Subtraction adds the inverted rhs with a carry of one into slice 0.
  // Later slices continue from the carry saved at the previous edge.
  always_comb rhs_eff = sub_op ? ~i_alu_rhs : i_alu_rhs;
  always_comb cin     = first ? sub_op : carry_q;

  always_comb sum = {1'b0, i_alu_lhs} + {1'b0, rhs_eff} + {{`IDLI_SLICE_W{1'b0}}, cin};

  // The immediate covers the two lowest slices and is zero-extended above.
  always_comb begin
    case (i_alu_ctr)
      ctr_t'(0): imm_slice = i_alu_imm[0 +: `IDLI_SLICE_W];
      ctr_t'(1): imm_slice = i_alu_imm[`IDLI_SLICE_W +: `IDLI_SLICE_W];
      default:   imm_slice = '0;
    endcase
  end

  // Output mux.
  // Compares also drive the sum so that the flags see the difference.
  always_comb begin
    case (i_alu_op)
      OP_LDI:  o_alu_out = imm_slice;
      OP_AND:  o_alu_out = i_alu_lhs & i_alu_rhs;
      OP_OR:   o_alu_out = i_alu_lhs | i_alu_rhs;
      OP_XOR:  o_alu_out = i_alu_lhs ^ i_alu_rhs;
      OP_ADD, OP_SUB, OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT,
      OP_CMP_LTU, OP_CMP_GE, OP_CMP_GEU: begin
        o_alu_out = sum[`IDLI_SLICE_W-1:0];
      end
      default: o_alu_out = '0;
    endcase
  end

  // The zero flag restarts in slice 0 and collects every later slice.
  always_comb zero_acc = (first || zero_q) && o_alu_out == '0;

  // Carry and zero are saved at every edge and are only read within a beat.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      carry_q <= 1'b0;
      zero_q  <= 1'b0;
    end else begin
      carry_q <= sum[`IDLI_SLICE_W];
      zero_q  <= zero_acc;
    end
  end

  // Flags describe the whole word once slice 3 is on the bus.
  // Overflow means both operands agree in sign but the result does not.
  always_comb o_alu_flag_z = zero_acc;
  always_comb o_alu_flag_n = sum[`IDLI_SLICE_W-1];
  always_comb o_alu_flag_c = sum[`IDLI_SLICE_W];
  always_comb o_alu_flag_v = (i_alu_lhs[`IDLI_SLICE_W-1] == rhs_eff[`IDLI_SLICE_W-1])
                          && (sum[`IDLI_SLICE_W-1] != i_alu_lhs[`IDLI_SLICE_W-1]);

endmodule

// File: verilog/idli_pred.sv
`timescale 1ns/1ps

`include "idli_settings.svh"

// Predicate register and conditional-execution mask.
// Decides whether the instruction in the current beat runs.
module idli_pred (
  input  var logic            i_ex_gck,
  input  var logic            i_ex_rst_n,

  input  var idli_pkg::ctr_t  i_pred_ctr,
  input  var logic            i_pred_vld,
  input  var idli_pkg::op_t   i_pred_op,
  input  var idli_pkg::imm_t  i_pred_imm,
  input  var logic            i_pred_dst_wr,

  input  var logic            i_pred_z,
  input  var logic            i_pred_n,
  input  var logic            i_pred_c,
  input  var logic            i_pred_v,

  output var logic            o_pred_reg_wr,
  output var logic            o_pred_run,
  output var logic            o_pred
);

  import idli_pkg::*;

  // Predicate bit written by compares.
  logic pred_q;

  // Mask of pending conditions, with bit 0 applying to the current beat.
  cond_t mask_q;

  // High while the mask still governs execution.
  logic mask_vld;

  // High in the last slice, where flags are final.
  logic last;

  // Compare result for the current opcode, and whether it is a compare.
  logic cmp_op;
  logic cmp_res;

  always_comb last = i_pred_ctr == ctr_t'(`IDLI_NUM_SLICES - 1);

  // Only bit 0 left set means the window has run out.
  always_comb mask_vld = |mask_q[$bits(cond_t)-1:1];

  // Inside the window an instruction runs only when P matches mask bit 0.
  // Neither state changes mid-beat, so the decision holds for all slices.
  always_comb o_pred_run = i_pred_vld && (!mask_vld || pred_q == mask_q[0]);

  always_comb o_pred_reg_wr = o_pred_run && i_pred_dst_wr;

  // Map the ALU flags to a predicate value for each compare type.
  always_comb begin
    cmp_op  = 1'b1;
    cmp_res = 1'b0;
    case (i_pred_op)
      OP_CMP_EQ:  cmp_res = i_pred_z;
      OP_CMP_NE:  cmp_res = !i_pred_z;
      OP_CMP_LT:  cmp_res = i_pred_n != i_pred_v;
      OP_CMP_LTU: cmp_res = !i_pred_c;
      OP_CMP_GE:  cmp_res = i_pred_n == i_pred_v;
      OP_CMP_GEU: cmp_res = i_pred_c;
      default:    cmp_op  = 1'b0;
    endcase
  end

  // Both registers change at the edge that ends slice 3.
  // Every accepted instruction consumes one mask bit, skipped or not.
  // A running COND loads a fresh mask instead of shifting.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
      mask_q <= '0;
    end else if (last && i_pred_vld) begin
      if (o_pred_run && cmp_op) begin
        pred_q <= cmp_res;
      end
      if (o_pred_run && i_pred_op == OP_COND) begin
        mask_q <= i_pred_imm;
      end else begin
        mask_q <= mask_q >> 1;
      end
    end
  end

  always_comb o_pred = pred_q;

endmodule

// File: verilog/idli_result.sv
`timescale 1ns/1ps

`include "idli_settings.svh"

// Result collection.
// Written slices are assembled into a word and reported once per beat.
module idli_result (
  input  var logic             i_ex_gck,
  input  var logic             i_ex_rst_n,

  input  var idli_pkg::ctr_t   i_res_ctr,
  input  var logic             i_res_wr,
  input  var idli_pkg::reg_t   i_res_dst,
  input  var idli_pkg::slice_t i_res_data,

  output var idli_pkg::word_t  o_res_word,
  output var idli_pkg::reg_t   o_res_dst,
  output var logic             o_res_vld
);

  import idli_pkg::*;

  // Slices arrive least significant first and enter from the top.
  word_t asm_q;
  word_t asm_d;

  // Reported word, destination and valid pulse.
  word_t word_q;
  reg_t  dst_q;
  logic  vld_q;

  logic last;

  always_comb last = i_res_ctr == ctr_t'(`IDLI_NUM_SLICES - 1);

  // After four shifts the first slice has moved down to the bottom.
  always_comb asm_d = {i_res_data, asm_q[`IDLI_WORD_W-1:`IDLI_SLICE_W]};

  always_ff @(posedge i_ex_gck) begin
    if (i_res_wr) begin
      asm_q <= asm_d;
    end
  end

  // The word is taken straight from the shift input in slice 3.
  always_ff @(posedge i_ex_gck) begin
    if (last && i_res_wr) begin
      word_q <= asm_d;
      dst_q  <= i_res_dst;
    end
  end

  // Writes to register 0 are discarded, so they are not reported either.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= last && i_res_wr && i_res_dst != '0;
    end
  end

  always_comb o_res_word = word_q;
  always_comb o_res_dst  = dst_q;
  always_comb o_res_vld  = vld_q;

endmodule

// File: verilog/idli_ex_top.sv
`timescale 1ns/1ps

// Top level of the execution unit.
module idli_ex_top (
  input  var logic            i_ex_gck,
  input  var logic            i_ex_rst_n,

  input  var idli_pkg::word_t i_ex_enc,
  input  var logic            i_ex_enc_vld,
  output var logic            o_ex_ready,

  output var idli_pkg::word_t o_ex_result,
  output var idli_pkg::reg_t  o_ex_result_dst,
  output var logic            o_ex_result_vld,
  output var logic            o_ex_pred
);

  import idli_pkg::*;

  // Decoded instruction, held for the whole beat.
  ctr_t ctr;
  logic vld;
  op_t  op;
  reg_t dst;
  reg_t lhs;
  reg_t rhs;
  imm_t imm;
  logic dst_wr;

  // Operand slices and ALU result.
  slice_t lhs_data;
  slice_t rhs_data;
  slice_t alu_out;

  // Flags of the full-word operation.
  logic flag_z;
  logic flag_n;
  logic flag_c;
  logic flag_v;

  // Register write enable from the predicate block.
  logic reg_wr;

  idli_decode decode_u (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_de_enc     (i_ex_enc),
    .i_de_enc_vld (i_ex_enc_vld),
    .o_de_ready   (o_ex_ready),
    .o_de_ctr     (ctr),
    .o_de_vld     (vld),
    .o_de_op      (op),
    .o_de_dst     (dst),
    .o_de_lhs     (lhs),
    .o_de_rhs     (rhs),
    .o_de_imm     (imm),
    .o_de_dst_wr  (dst_wr)
  );

  idli_rf rf_u (
    .i_ex_gck      (i_ex_gck),
    .i_rf_ctr      (ctr),
    .i_rf_lhs      (lhs),
    .i_rf_rhs      (rhs),
    .i_rf_dst      (dst),
    .i_rf_dst_en   (reg_wr),
    .i_rf_dst_data (alu_out),
    .o_rf_lhs_data (lhs_data),
    .o_rf_rhs_data (rhs_data)
  );

  idli_alu alu_u (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_alu_ctr    (ctr),
    .i_alu_op     (op),
    .i_alu_imm    (imm),
    .i_alu_lhs    (lhs_data),
    .i_alu_rhs    (rhs_data),
    .o_alu_out    (alu_out),
    .o_alu_flag_z (flag_z),
    .o_alu_flag_n (flag_n),
    .o_alu_flag_c (flag_c),
    .o_alu_flag_v (flag_v)
  );

  // The register write enable already folds in the run decision.
  idli_pred pred_u (
    .i_ex_gck      (i_ex_gck),
    .i_ex_rst_n    (i_ex_rst_n),
    .i_pred_ctr    (ctr),
    .i_pred_vld    (vld),
    .i_pred_op     (op),
    .i_pred_imm    (imm),
    .i_pred_dst_wr (dst_wr),
    .i_pred_z      (flag_z),
    .i_pred_n      (flag_n),
    .i_pred_c      (flag_c),
    .i_pred_v      (flag_v),
    .o_pred_reg_wr (reg_wr),
    .o_pred_run    (),
    .o_pred        (o_ex_pred)
  );

  idli_result result_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_res_ctr  (ctr),
    .i_res_wr   (reg_wr),
    .i_res_dst  (dst),
    .i_res_data (alu_out),
    .o_res_word (o_ex_result),
    .o_res_dst  (o_ex_result_dst),
    .o_res_vld  (o_ex_result_vld)
  );

endmodule

// File: sim/idli_tb.sv
`timescale 1ns/1ps

`include "idli_settings.svh"

// Testbench for the nibble-serial execution unit.
// Instructions are issued back to back, one per beat, from a table of steps.
module idli_tb;

  import idli_pkg::*;

  // DUT connections.
  logic  i_ex_gck = 1'b0;
  logic  i_ex_rst_n;
  word_t i_ex_enc;
  logic  i_ex_enc_vld;
  logic  o_ex_ready;
  word_t o_ex_result;
  reg_t  o_ex_result_dst;
  logic  o_ex_result_vld;
  logic  o_ex_pred;

  // Table of steps.
  // Each step is an encoding (or a bubble) with the report and predicate it should give.
  logic  step_vld  [$];
  word_t step_enc  [$];
  logic  step_rpt  [$];
  word_t step_word [$];
  reg_t  step_dst  [$];
  logic  step_pred [$];

  // Architectural state of the reference model.
  word_t m_regs [`IDLI_NUM_REGS];
  logic  m_pred;
  cond_t m_mask;

  int     errors = 0;
  int     checks = 0;
  integer seed   = 32'h4e96_031e;

  idli_ex_top dut (
    .i_ex_gck        (i_ex_gck),
    .i_ex_rst_n      (i_ex_rst_n),
    .i_ex_enc        (i_ex_enc),
    .i_ex_enc_vld    (i_ex_enc_vld),
    .o_ex_ready      (o_ex_ready),
    .o_ex_result     (o_ex_result),
    .o_ex_result_dst (o_ex_result_dst),
    .o_ex_result_vld (o_ex_result_vld),
    .o_ex_pred       (o_ex_pred)
  );

  always #20 i_ex_gck = ~i_ex_gck;

  // Reference model of one beat.
  // It applies the mask rule, then the register, predicate and mask updates.
  task automatic model_step(input logic vld, input word_t enc, output logic rpt,
                            output word_t res, output reg_t dst);
    op_t  op;
    word_t a;
    word_t b;
    logic run;
    logic wr;
    logic cmp;
    logic res_p;
    rpt   = 1'b0;
    res   = '0;
    dst   = enc[11:8];
    op    = op_t'(enc[15:12]);
    a     = m_regs[enc[7:4]];
    b     = m_regs[enc[3:0]];
    // Only LDI and the ALU operations write a register.
    // Only compares write the predicate.
    wr    = op inside {OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    cmp   = op inside {OP_CMP_EQ, OP_CMP_NE, OP_CMP_LT, OP_CMP_LTU, OP_CMP_GE, OP_CMP_GEU};
    res_p = 1'b0;
    // A bubble leaves the model untouched.
    if (vld) begin
      run = (m_mask[7:1] == 7'd0) || (m_pred == m_mask[0]);
      case (op)
        OP_LDI:     res = {8'h00, enc[7:0]};
        OP_ADD:     res = a + b;
        OP_SUB:     res = a - b;
        OP_AND:     res = a & b;
        OP_OR:      res = a | b;
        OP_XOR:     res = a ^ b;
        OP_CMP_EQ:  res_p = a == b;
        OP_CMP_NE:  res_p = a != b;
        OP_CMP_LT:  res_p = $signed(a) < $signed(b);
        OP_CMP_LTU: res_p = a < b;
        OP_CMP_GE:  res_p = $signed(a) >= $signed(b);
        OP_CMP_GEU: res_p = a >= b;
        default:    res = '0;
      endcase
      // Register 0 keeps its zero and is never reported.
      if (run && wr && dst != 4'd0) begin
        m_regs[dst] = res;
        rpt = 1'b1;
      end
      if (run && cmp) begin
        m_pred = res_p;
      end
      if (run && op == OP_COND) begin
        m_mask = enc[7:0];
      end else begin
        m_mask = m_mask >> 1;
      end
    end
  endtask

  // Directed step with expected values written out by hand.
  // The model still steps so that its state follows the DUT.
  task automatic add_step(input word_t enc, input logic rpt, input word_t word,
                          input reg_t dst, input logic pred);
    logic  m_rpt;
    word_t m_word;
    reg_t  m_dst;
    model_step(1'b1, enc, m_rpt, m_word, m_dst);
    step_vld.push_back(1'b1);
    step_enc.push_back(enc);
    step_rpt.push_back(rpt);
    step_word.push_back(word);
    step_dst.push_back(dst);
    step_pred.push_back(pred);
  endtask

  task automatic add_bubble(input logic pred);
    step_vld.push_back(1'b0);
    step_enc.push_back(16'h0000);
    step_rpt.push_back(1'b0);
    step_word.push_back(16'h0000);
    step_dst.push_back(4'd0);
    step_pred.push_back(pred);
  endtask

  // Step whose expected values come from the model.
  task automatic add_modeled(input logic vld, input word_t enc);
    logic  rpt;
    word_t word;
    reg_t  dst;
    model_step(vld, enc, rpt, word, dst);
    step_vld.push_back(vld);
    step_enc.push_back(enc);
    step_rpt.push_back(rpt);
    step_word.push_back(word);
    step_dst.push_back(dst);
    step_pred.push_back(m_pred);
  endtask

  task automatic build_directed();
    // Loads, including one to register 0 that must stay silent.
    add_step(16'h1134, 1'b1, 16'h0034, 4'd1, 1'b0);
    add_step(16'h12ff, 1'b1, 16'h00ff, 4'd2, 1'b0);
    add_step(16'h1380, 1'b1, 16'h0080, 4'd3, 1'b0);
    add_step(16'h1055, 1'b0, 16'h0000, 4'd0, 1'b0);
    add_step(16'h1401, 1'b1, 16'h0001, 4'd4, 1'b0);
    // ALU chain where each step reads the result of the one before.
    add_step(16'h2522, 1'b1, 16'h01fe, 4'd5, 1'b0);
    add_step(16'h2555, 1'b1, 16'h03fc, 4'd5, 1'b0);
    add_step(16'h3651, 1'b1, 16'h03c8, 4'd6, 1'b0);
    add_step(16'h3746, 1'b1, 16'hfc39, 4'd7, 1'b0);
    add_step(16'h4876, 1'b1, 16'h0008, 4'd8, 1'b0);
    add_step(16'h5987, 1'b1, 16'hfc39, 4'd9, 1'b0);
    add_step(16'h6a96, 1'b1, 16'hfff1, 4'd10, 1'b0);
    add_step(16'h2ba4, 1'b1, 16'hfff2, 4'd11, 1'b0);
    add_step(16'h2ca9, 1'b1, 16'hfc2a, 4'd12, 1'b0);
    // Every compare type, with the predicate toggling on each.
    add_step(16'h7011, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_step(16'h8011, 1'b0, 16'h0000, 4'd0, 1'b0);
    add_step(16'h9074, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_step(16'ha074, 1'b0, 16'h0000, 4'd0, 1'b0);
    add_step(16'hb047, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_step(16'hc012, 1'b0, 16'h0000, 4'd0, 1'b0);
    add_step(16'hc021, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_step(16'h9044, 1'b0, 16'h0000, 4'd0, 1'b0);
    // Mask 0x06 with P clear runs one, skips one, then the window is empty.
    add_step(16'hd006, 1'b0, 16'h0000, 4'd0, 1'b0);
    add_step(16'h1d11, 1'b1, 16'h0011, 4'd13, 1'b0);
    add_step(16'h1d22, 1'b0, 16'h0000, 4'd0, 1'b0);
    add_step(16'h1e33, 1'b1, 16'h0033, 4'd14, 1'b0);
    // With P set, mask 0x0a skips one and runs one.
    // The bubbles in between must not consume mask bits.
    add_step(16'h70dd, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_step(16'hd00a, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_bubble(1'b1);
    add_step(16'h2fde, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_bubble(1'b1);
    add_step(16'h2fed, 1'b1, 16'h0044, 4'd15, 1'b1);
    // A skipped compare leaves P alone.
    add_step(16'h80dd, 1'b0, 16'h0000, 4'd0, 1'b1);
    add_step(16'h6ffd, 1'b1, 16'h0055, 4'd15, 1'b1);
    add_step(16'h0000, 1'b0, 16'h0000, 4'd0, 1'b1);
  endtask

  task automatic build_random();
    logic [31:0] r;
    word_t       enc;
    // Give every register a known value first.
    for (int n = 1; n < `IDLI_NUM_REGS; n++) begin
      r = $random(seed);
      enc = {OP_LDI, reg_t'(n), r[7:0]};
      add_modeled(1'b1, enc);
    end
    for (int n = 0; n < 200; n++) begin
      r = $random(seed);
      enc = r[15:0];
      enc[15:12] = r[19:16] % 4'd14;
      // Roughly one beat in sixteen is a bubble.
      add_modeled(r[23:20] != 4'h0, enc);
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s result word %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_dst(input reg_t got, input reg_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s destination %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_pred(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s predicate %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called in the first cycle of the beat after the step executed.
  task automatic check_step(input int idx);
    int    errs_before;
    string what;
    string label;
    op_t   op;
    errs_before = errors;
    what = $sformatf("step %0d", idx);
    op = op_t'(step_enc[idx][15:12]);
    label = step_vld[idx] ? op.name() : "bubble";
    if (step_rpt[idx]) begin
      if (o_ex_result_vld !== 1'b1) begin
        $display("At %0t ns step %0d gave no result pulse within five cycles of acceptance",
                 $time, idx);
        errors++;
      end else begin
        check_word(o_ex_result, step_word[idx], what);
        check_dst(o_ex_result_dst, step_dst[idx], what);
      end
    end else if (o_ex_result_vld !== 1'b0) begin
      $display("At %0t ns step %0d gave a result pulse where none belongs", $time, idx);
      errors++;
    end
    check_pred(o_ex_pred, step_pred[idx], what);
    checks++;
    $display("step %0d %s %h: %s", idx, label, step_enc[idx],
             (errors == errs_before) ? "ok" : "error");
  endtask

  // Steps falling edges until ready is seen.
  task automatic wait_ready(input int idx, output logic timed_out);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 8 && !seen; n++) begin
      @(negedge i_ex_gck);
      seen = o_ex_ready;
    end
    timed_out = !seen;
    if (!seen) begin
      $display("Timed out waiting for ready before step %0d", idx);
      errors++;
    end
  endtask

  initial begin
    logic timed_out;
    i_ex_rst_n   = 1'b0;
    i_ex_enc     = '0;
    i_ex_enc_vld = 1'b0;
    timed_out    = 1'b0;
    for (int n = 0; n < `IDLI_NUM_REGS; n++) begin
      m_regs[n] = '0;
    end
    m_pred = 1'b0;
    m_mask = '0;
    build_directed();
    build_random();

    repeat (8) @(negedge i_ex_gck);
    i_ex_rst_n = 1'b1;

    // The result of each step shows one cycle after the next step is accepted.
    // One more bubble beat after the table lets the last step report.
    for (int i = 0; i <= step_enc.size() && !timed_out; i++) begin
      wait_ready(i, timed_out);
      if (!timed_out) begin
        if (i < step_enc.size()) begin
          i_ex_enc     = step_enc[i];
          i_ex_enc_vld = step_vld[i];
        end
        @(negedge i_ex_gck);
        i_ex_enc_vld = 1'b0;
        if (i > 0) begin
          check_step(i - 1);
        end
      end
    end

    $display("%0d steps checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verilog
verilog/idli_pkg.sv
verilog/idli_decode.sv
verilog/idli_rf.sv
verilog/idli_alu.sv
verilog/idli_pred.sv
verilog/idli_result.sv
verilog/idli_ex_top.sv
sim/idli_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := idli_tb
FILELIST  := all.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

# The simulator is rebuilt only when a source, a header or the file list changes.
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
